/* logic/coherence_pkg.sv */
package coherence_pkg;

	// data and address word of both buses
	typedef logic [31:0] word_t;

	// cache ports on the bus
	// port vectors are indexed by cache number
	parameter int NUM_CACHES = 2;

	// default wait cycles of the memory model
	parameter int DEFAULT_MEM_LATENCY = 2;

	// bus controller states
	typedef enum logic [2:0] {
		// idle, waiting for any request level
		REQUEST,
		// pick the cache to serve
		ARBITRATE,
		// snoop the other cache
		SNOOP,
		// other cache holds a dirty copy, write it back first
		MODIFIED_WB,
		// plain write-back of the granted cache
		MEMORY_WB,
		// fetch the word from memory
		MEMORY_READ,
		// hand the read word to the requester
		COMPLETE
	} bus_state_t;

endpackage

/* logic/cache_ctrl_if.sv */
`timescale 1ns/10ps

interface cache_ctrl_if;

	// request levels, one bit per cache
	// held until the cache sees its dwait low
	logic [coherence_pkg::NUM_CACHES-1:0] dren;
	logic [coherence_pkg::NUM_CACHES-1:0] dwen;
	logic [coherence_pkg::NUM_CACHES-1:0] ccwrite;

	// address and store data per cache
	coherence_pkg::word_t [coherence_pkg::NUM_CACHES-1:0] daddr;
	coherence_pkg::word_t [coherence_pkg::NUM_CACHES-1:0] dstore;

	// idle high, one low cycle ends a request
	logic [coherence_pkg::NUM_CACHES-1:0] dwait;
	// read word, valid while dwait is low
	coherence_pkg::word_t [coherence_pkg::NUM_CACHES-1:0] dload;

	// snoop side toward each cache
	logic [coherence_pkg::NUM_CACHES-1:0] ccwait;
	logic [coherence_pkg::NUM_CACHES-1:0] ccinv;
	coherence_pkg::word_t [coherence_pkg::NUM_CACHES-1:0] ccsnoopaddr;

	// bus controller side
	modport cc (
		input dren, dwen, ccwrite, daddr, dstore,
		output dwait, dload, ccwait, ccinv, ccsnoopaddr
	);

	// top level side, fed from the cache ports
	modport top (
		output dren, dwen, ccwrite, daddr, dstore,
		input dwait, dload, ccwait, ccinv, ccsnoopaddr
	);

endinterface

/* logic/bus_mem_if.sv */
`timescale 1ns/10ps

interface bus_mem_if;

	// request, held steady until dwait is low
	logic ren;
	logic wen;
	coherence_pkg::word_t addr;
	coherence_pkg::word_t store;

	// memory answer
	// dwait low for exactly one cycle, load valid on that cycle
	coherence_pkg::word_t load;
	logic dwait;

	modport bus_con (
		output ren, wen, addr, store,
		input load, dwait
	);

	modport mem (
		input ren, wen, addr, store,
		output load, dwait
	);

endinterface

/* logic/bus_control.sv */
`timescale 1ns/10ps

module bus_control (
	input logic CLK,
	input logic nRST,
	cache_ctrl_if.cc ccif,
	bus_mem_if.bus_con bmif
);

	coherence_pkg::bus_state_t state, next_state;
	// last granted cache, round-robin pointer
	logic granted, next_granted;
	// winner of this cycle's arbitration
	logic arb_pick;
	// cache the bus currently works for
	logic cur;
	// any request level per cache
	logic [coherence_pkg::NUM_CACHES-1:0] req;
	// read word kept for COMPLETE
	coherence_pkg::word_t return_val;

	assign req = ccif.dren | ccif.dwen | ccif.ccwrite;

	// on a tie the cache not served last wins
	always_comb begin
		if (req[0] && req[1]) begin
			arb_pick = !granted;
		end else begin
			arb_pick = req[1];
		end
	end

	// grant takes effect already in ARBITRATE
	assign cur = (state == coherence_pkg::ARBITRATE) ? arb_pick : granted;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= coherence_pkg::REQUEST;
			granted <= 1'b0;
		end else begin
			state <= next_state;
			granted <= next_granted;
		end
	end

	// capture memory load on the last read cycle
	always_ff @(posedge CLK) begin
		if (state == coherence_pkg::MEMORY_READ && !bmif.dwait) begin
			return_val <= bmif.load;
		end
	end

	always_comb begin
		next_state = state;
		next_granted = granted;

		// idle values toward caches
		ccif.dwait = '1;
		ccif.dload = '0;
		ccif.ccinv = '0;
		ccif.ccsnoopaddr = '0;
		// other cache held off while a transaction runs
		ccif.ccwait = '1;
		ccif.ccwait[cur] = 1'b0;

		// memory idle
		bmif.ren = 1'b0;
		bmif.wen = 1'b0;
		bmif.addr = '0;
		bmif.store = '0;

		case (state)
			coherence_pkg::REQUEST: begin
				// no snoop traffic while idle
				ccif.ccwait = '0;
				if (|req) begin
					next_state = coherence_pkg::ARBITRATE;
				end
			end

			coherence_pkg::ARBITRATE: begin
				next_granted = arb_pick;
				// reads and write-intents go through a snoop
				if (ccif.dren[arb_pick] || ccif.ccwrite[arb_pick]) begin
					next_state = coherence_pkg::SNOOP;
				end else begin
					next_state = coherence_pkg::MEMORY_WB;
				end
			end

			coherence_pkg::SNOOP: begin
				ccif.ccsnoopaddr[0] = ccif.daddr[granted];
				ccif.ccsnoopaddr[1] = ccif.daddr[granted];
				if (ccif.ccwrite[granted] && !ccif.dren[granted]) begin
					// write-intent, kill the other copy and finish
					ccif.ccinv[!granted] = 1'b1;
					ccif.dwait[granted] = 1'b0;
					next_state = coherence_pkg::REQUEST;
				end else if (ccif.ccwrite[!granted]) begin
					// other cache has it dirty
					next_state = coherence_pkg::MODIFIED_WB;
				end else begin
					next_state = coherence_pkg::MEMORY_READ;
				end
			end

			coherence_pkg::MODIFIED_WB: begin
				// other cache's data lands at the requester's address
				bmif.wen = 1'b1;
				bmif.addr = ccif.daddr[granted];
				bmif.store = ccif.dstore[!granted];
				if (!bmif.dwait) begin
					next_state = coherence_pkg::MEMORY_READ;
				end
			end

			coherence_pkg::MEMORY_WB: begin
				bmif.wen = 1'b1;
				bmif.addr = ccif.daddr[granted];
				bmif.store = ccif.dstore[granted];
				// requester released on the memory's ack cycle
				ccif.dwait[granted] = bmif.dwait;
				if (!bmif.dwait) begin
					next_state = coherence_pkg::REQUEST;
				end
			end

			coherence_pkg::MEMORY_READ: begin
				bmif.ren = 1'b1;
				bmif.addr = ccif.daddr[granted];
				if (!bmif.dwait) begin
					next_state = coherence_pkg::COMPLETE;
				end
			end

			coherence_pkg::COMPLETE: begin
				ccif.dwait[granted] = 1'b0;
				ccif.dload[granted] = return_val;
				next_state = coherence_pkg::REQUEST;
			end

			default: begin
				next_state = coherence_pkg::REQUEST;
			end
		endcase
	end

endmodule

/* logic/wait_state_memory.sv */
`timescale 1ns/10ps

module wait_state_memory #(
	parameter int MEM_LATENCY = coherence_pkg::DEFAULT_MEM_LATENCY,
	parameter int MEM_DEPTH_WORDS = 256
) (
	input logic CLK,
	input logic nRST,
	bus_mem_if.mem bmif
);

	// counter wide enough to reach MEM_LATENCY
	localparam int CNT_W = $clog2(MEM_LATENCY + 2);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(MEM_LATENCY);

	coherence_pkg::word_t mem_array [MEM_DEPTH_WORDS];
	// held cycles of the current request
	logic [CNT_W-1:0] wait_cnt;
	logic active;
	// ack cycle
	logic done;
	// word index, wraps at the depth
	coherence_pkg::word_t index;

	assign active = bmif.ren | bmif.wen;
	assign done = active && (wait_cnt == LAST_CNT);
	assign index = (bmif.addr >> 2) % MEM_DEPTH_WORDS;

	assign bmif.dwait = !done;
	assign bmif.load = (done && bmif.ren) ? mem_array[index] : '0;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wait_cnt <= '0;
			for (int i = 0; i < MEM_DEPTH_WORDS; i++) begin
				mem_array[i] <= '0;
			end
		end else begin
			// restart after the ack so the next request waits in full
			if (done || !active) begin
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
			// write takes effect on the ack cycle
			if (done && bmif.wen) begin
				mem_array[index] <= bmif.store;
			end
		end
	end

endmodule

/* logic/coherence_top.sv */
`timescale 1ns/10ps

module coherence_top #(
	parameter int MEM_LATENCY = coherence_pkg::DEFAULT_MEM_LATENCY,
	parameter int MEM_DEPTH_WORDS = 256
) (
	input logic CLK,
	input logic nRST,
	input logic [1:0] dren,
	input logic [1:0] dwen,
	input logic [1:0] ccwrite,
	input coherence_pkg::word_t daddr0,
	input coherence_pkg::word_t daddr1,
	input coherence_pkg::word_t dstore0,
	input coherence_pkg::word_t dstore1,
	output logic [1:0] dwait,
	output logic [1:0] ccwait,
	output logic [1:0] ccinv,
	output coherence_pkg::word_t dload0,
	output coherence_pkg::word_t dload1,
	output coherence_pkg::word_t ccsnoopaddr0,
	output coherence_pkg::word_t ccsnoopaddr1
);

	cache_ctrl_if ccif ();
	bus_mem_if bmif ();

	// cache 0 and cache 1 request side
	assign ccif.dren = dren;
	assign ccif.dwen = dwen;
	assign ccif.ccwrite = ccwrite;
	assign ccif.daddr[0] = daddr0;
	assign ccif.daddr[1] = daddr1;
	assign ccif.dstore[0] = dstore0;
	assign ccif.dstore[1] = dstore1;

	// controller answers back out to the caches
	assign dwait = ccif.dwait;
	assign ccwait = ccif.ccwait;
	assign ccinv = ccif.ccinv;
	assign dload0 = ccif.dload[0];
	assign dload1 = ccif.dload[1];
	assign ccsnoopaddr0 = ccif.ccsnoopaddr[0];
	assign ccsnoopaddr1 = ccif.ccsnoopaddr[1];

	bus_control bus_control_i (
		.CLK (CLK),
		.nRST (nRST),
		.ccif (ccif.cc),
		.bmif (bmif.bus_con)
	);

	wait_state_memory #(
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
	) wait_state_memory_i (
		.CLK (CLK),
		.nRST (nRST),
		.bmif (bmif.mem)
	);

endmodule

/* verif/coherence_top_properties.sv */
`timescale 1ns/10ps

module coherence_top_properties (
	input logic CLK,
	input logic nRST,
	input coherence_pkg::bus_state_t state,
	input logic granted,
	input logic [1:0] dwait,
	input logic [1:0] ccwait,
	input logic [1:0] ccinv,
	input logic mem_ren,
	input logic mem_wen,
	input coherence_pkg::word_t mem_addr,
	input logic mem_dwait
);

	// failed assertions so far
	int fail_count = 0;

	// at most one cache held off, never the one being answered
	ccwait_not_both: assert property (@(posedge CLK) disable iff (!nRST)
		!(&ccwait) && ((ccwait & ~dwait) == 2'b00))
		else begin
			fail_count++;
			$error("ccwait high on both caches or on the answered cache");
		end

	// invalidate only in a write-intent snoop while the requester is released
	ccinv_not_requester: assert property (@(posedge CLK) disable iff (!nRST)
		(|ccinv) |-> (state == coherence_pkg::SNOOP && !ccinv[granted] && !dwait[granted]))
		else begin
			fail_count++;
			$error("ccinv raised outside a write-intent snoop or on the granted cache");
		end

	mem_one_op: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
		else begin
			fail_count++;
			$error("memory read and write requested together");
		end

	// request held steady through the wait cycles
	mem_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_ren || mem_wen) && mem_dwait |=> $stable(mem_addr))
		else begin
			fail_count++;
			$error("memory address changed while waiting");
		end

	// one low cycle ends a request
	dwait0_pulse: assert property (@(posedge CLK) disable iff (!nRST) !dwait[0] |=> dwait[0])
		else begin
			fail_count++;
			$error("dwait of cache 0 low for more than one cycle");
		end
	dwait1_pulse: assert property (@(posedge CLK) disable iff (!nRST) !dwait[1] |=> dwait[1])
		else begin
			fail_count++;
			$error("dwait of cache 1 low for more than one cycle");
		end

endmodule

/* verif/coherence_top_tb.sv */
`timescale 1ns/10ps

module coherence_top_tb;

	// roughly 50 requests of a dozen cycles or less, wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic CLK;
	logic nRST;
	logic [1:0] dren, dwen, ccwrite;
	coherence_pkg::word_t daddr0, daddr1, dstore0, dstore1;
	logic [1:0] dwait, ccwait, ccinv;
	coherence_pkg::word_t dload0, dload1, ccsnoopaddr0, ccsnoopaddr1;

	int errors, checks, cycles;
	logic [15:0] lfsr_state;
	// expected memory, keyed by word index
	coherence_pkg::word_t model_mem [int];
	// cache of each dwait pulse, in order
	logic done_order [$];
	// snoop side seen on the last completion
	logic [1:0] last_inv;
	coherence_pkg::word_t last_snoop0, last_snoop1;

	coherence_top #(.MEM_LATENCY(2)) dut_i (.*);

	bind bus_control coherence_top_properties props_i (
		.CLK (CLK),
		.nRST (nRST),
		.state (state),
		.granted (granted),
		.dwait (ccif.dwait),
		.ccwait (ccif.ccwait),
		.ccinv (ccif.ccinv),
		.mem_ren (bmif.ren),
		.mem_wen (bmif.wen),
		.mem_addr (bmif.addr),
		.mem_dwait (bmif.dwait)
	);

	always #2 CLK = !CLK;

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a request never finished", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic coherence_pkg::word_t random_bits(input int n);
		coherence_pkg::word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// word aligned, wraps at 256 words
	function automatic int word_index(input coherence_pkg::word_t addr);
		return int'((addr >> 2) % 256);
	endfunction

	function automatic coherence_pkg::word_t model_read(input coherence_pkg::word_t addr);
		int k;
		k = word_index(addr);
		// memory is cleared at reset
		return model_mem.exists(k) ? model_mem[k] : '0;
	endfunction

	task automatic check_word(input string name, input coherence_pkg::word_t exp,
			input coherence_pkg::word_t act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_idle(input string name);
		check_word({name, " dwait"}, 32'h3, 32'(dwait));
		check_word({name, " ccinv"}, 32'h0, 32'(ccinv));
		check_word({name, " ccwait"}, 32'h0, 32'(ccwait));
	endtask

	task automatic drive_cache(input logic c, input logic rd, input logic wr, input logic cw,
			input coherence_pkg::word_t addr, input coherence_pkg::word_t data);
		dren[c] = rd;
		dwen[c] = wr;
		ccwrite[c] = cw;
		if (c) begin
			daddr1 = addr;
			dstore1 = data;
		end else begin
			daddr0 = addr;
			dstore0 = data;
		end
	endtask

	// hold the request until own dwait is low, drop it one cycle later
	task automatic bus_request(input logic c, input logic rd, input logic wr, input logic cw,
			input coherence_pkg::word_t addr, input coherence_pkg::word_t data,
			output coherence_pkg::word_t got);
		drive_cache(c, rd, wr, cw, addr, data);
		@(negedge CLK);
		while (dwait[c]) begin
			@(negedge CLK);
		end
		got = c ? dload1 : dload0;
		last_inv = ccinv;
		last_snoop0 = ccsnoopaddr0;
		last_snoop1 = ccsnoopaddr1;
		done_order.push_back(c);
		@(posedge CLK);
		#0.5;
		drive_cache(c, 1'b0, 1'b0, 1'b0, '0, '0);
	endtask

	// cache 0 answers the snoop with a modified copy
	task automatic supply_dirty(input coherence_pkg::word_t addr,
			input coherence_pkg::word_t data);
		drive_cache(1'b0, 1'b0, 1'b0, 1'b1, addr, data);
		@(negedge CLK);
		while (dwait[1]) begin
			@(negedge CLK);
		end
		@(posedge CLK);
		#0.5;
		drive_cache(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
	endtask

	initial begin
		coherence_pkg::word_t addrs [8];
		coherence_pkg::word_t got, got1, val, a0, a1, d0, d1;
		int assert_fails;
		CLK = 1'b0;
		nRST = 1'b0;
		dren = '0;
		dwen = '0;
		ccwrite = '0;
		daddr0 = '0;
		daddr1 = '0;
		dstore0 = '0;
		dstore1 = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		lfsr_state = 16'd76;

		// reset state, during and right after
		repeat (4) begin
			@(negedge CLK);
			check_idle("reset");
		end
		@(posedge CLK);
		#0.5;
		nRST = 1'b1;
		@(negedge CLK);
		check_idle("after reset");
		@(posedge CLK);
		#0.5;

		// cache 0 writes back, cache 1 reads clean
		for (int i = 0; i < 8; i++) begin
			addrs[i] = random_bits(6) << 2;
			val = random_bits(32);
			bus_request(1'b0, 1'b0, 1'b1, 1'b0, addrs[i], val, got);
			model_mem[word_index(addrs[i])] = val;
		end
		for (int i = 0; i < 8; i++) begin
			bus_request(1'b1, 1'b1, 1'b0, 1'b0, addrs[i], '0, got);
			check_word("write-back then read", model_read(addrs[i]), got);
		end

		// write-intent, no memory traffic
		bus_request(1'b0, 1'b0, 1'b0, 1'b1, addrs[0], random_bits(32), got);
		check_word("invalidate ccinv", 32'h2, 32'(last_inv));
		check_word("invalidate snoop addr 0", addrs[0], last_snoop0);
		check_word("invalidate snoop addr 1", addrs[0], last_snoop1);
		bus_request(1'b0, 1'b1, 1'b0, 1'b0, addrs[0], '0, got);
		check_word("memory after invalidate", model_read(addrs[0]), got);

		// last grant went to cache 0, so cache 1 wins the tie
		val = random_bits(32);
		fork
			bus_request(1'b1, 1'b1, 1'b0, 1'b0, addrs[1], '0, got1);
			supply_dirty(addrs[1], val);
		join
		check_word("dirty read", val, got1);
		model_mem[word_index(addrs[1])] = val;
		bus_request(1'b0, 1'b1, 1'b0, 1'b0, addrs[1], '0, got);
		check_word("dirty data written back", val, got);

		// both caches request together, writes then reads
		done_order.delete();
		for (int r = 0; r < 8; r++) begin
			// a lone cache 1 read halfway turns the round-robin pointer
			if (r == 4) begin
				bus_request(1'b1, 1'b1, 1'b0, 1'b0, a1, '0, got1);
				check_word("arbitration lone read", model_read(a1), got1);
			end
			if (!r[0]) begin
				a0 = 32'h100 + (random_bits(4) << 2);
				a1 = 32'h200 + (random_bits(4) << 2);
				d0 = random_bits(32);
				d1 = random_bits(32);
			end
			fork
				bus_request(1'b0, r[0], !r[0], 1'b0, a0, d0, got);
				bus_request(1'b1, r[0], !r[0], 1'b0, a1, d1, got1);
			join
			if (r[0]) begin
				check_word("arbitration read 0", model_read(a0), got);
				check_word("arbitration read 1", model_read(a1), got1);
			end else begin
				model_mem[word_index(a0)] = d0;
				model_mem[word_index(a1)] = d1;
			end
		end
		// ties go to the cache not served last, so every pulse alternates
		check_word("arbitration pulse count", 32'd17, 32'(done_order.size()));
		for (int k = 1; k < done_order.size(); k++) begin
			check_word("arbitration order", 32'(!done_order[k-1]), 32'(done_order[k]));
		end

		repeat (4) @(posedge CLK);
		assert_fails = dut_i.bus_control_i.props_i.fail_count;
		$display("checks %0d errors %0d assertion failures %0d", checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* coherence_bus.f */
logic/coherence_pkg.sv
logic/cache_ctrl_if.sv
logic/bus_mem_if.sv
logic/bus_control.sv
logic/wait_state_memory.sv
logic/coherence_top.sv
verif/coherence_top_properties.sv
verif/coherence_top_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP = coherence_top_tb
FILELIST = coherence_bus.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)
